//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetchStage2Tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIMFLAGS  ?=

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(BUILD_DIR)

//--- design/ctrlQueue.sv
/*
 * Control-transfer queue
 * Circular queue that tags control instructions in program order,
 * records their resolution from execute, discards younger entries on
 * an execute squash and retires the head on commit. Each retired
 * entry drives a registered predictor update one cycle later.
 */

`timescale 1ns/1ns

module ctrlQueue
  import fetchPkg::*;
(
  input  logic                                     clk,
  input  logic                                     rst_i,
  input  logic [FETCH_WIDTH-1:0]                   alloc_i,
  input  logic                                     allocEn_i,
  input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]      slotPc_i,
  input  ctrlClassT [FETCH_WIDTH-1:0]              slotClass_i,
  output logic [FETCH_WIDTH-1:0][CTI_TAG_WIDTH-1:0] tag_o,
  output logic                                     full_o,
  input  logic [CTI_TAG_WIDTH-1:0]                 ctiQueueIndex_i,
  input  logic [PC_WIDTH-1:0]                      targetAddr_i,
  input  logic                                     branchOutcome_i,
  input  logic                                     ctrlVerified_i,
  input  logic                                     flagRecoverEx_i,
  input  logic                                     commitCti_i,
  output logic [PC_WIDTH-1:0]                      updatePc_o,
  output logic [PC_WIDTH-1:0]                      updateTargetAddr_o,
  output ctrlClassT                                updateCtrlClass_o,
  output logic                                     updateDir_o,
  output logic                                     updateEn_o
);

  logic [PC_WIDTH-1:0]        entryPc     [CTI_QUEUE_DEPTH];
  ctrlClassT                  entryClass  [CTI_QUEUE_DEPTH];
  logic [PC_WIDTH-1:0]        entryTarget [CTI_QUEUE_DEPTH];
  logic [CTI_QUEUE_DEPTH-1:0] entryDir;
  logic [CTI_QUEUE_DEPTH-1:0] entryResolved;

  logic [CTI_TAG_WIDTH-1:0]   head;
  logic [CTI_TAG_WIDTH-1:0]   tail;
  logic [CTI_COUNT_WIDTH-1:0] count;
  logic [CTI_TAG_WIDTH-1:0]   allocNum;
  logic                       commitFire;
  logic [CTI_TAG_WIDTH-1:0]   keepOffset;
  logic [CTI_COUNT_WIDTH-1:0] keepCount;

  // Each slot's tag is the tail plus the allocations ahead of it
  always_comb begin
    logic [CTI_TAG_WIDTH-1:0] offset;
    offset = '0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      tag_o[k] = tail + offset;
      offset   = offset + CTI_TAG_WIDTH'(alloc_i[k]);
    end
    allocNum = allocEn_i ? offset : '0;
  end

  assign full_o     = count > CTI_COUNT_WIDTH'(CTI_QUEUE_DEPTH - FETCH_WIDTH);
  assign commitFire = commitCti_i & (count != '0) & entryResolved[head];

  // Squashed index itself stays in the queue
  assign keepOffset = ctiQueueIndex_i - head;
  assign keepCount  = {1'b0, keepOffset} + CTI_COUNT_WIDTH'(1);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      head          <= '0;
      tail          <= '0;
      count         <= '0;
      entryResolved <= '0;
      updateEn_o    <= 1'b0;
    end else begin
      updateEn_o <= commitFire;
      if (commitFire) begin
        head <= head + CTI_TAG_WIDTH'(1);
      end
      if (flagRecoverEx_i) begin
        tail  <= ctiQueueIndex_i + CTI_TAG_WIDTH'(1);
        count <= keepCount - CTI_COUNT_WIDTH'(commitFire);
      end else begin
        tail  <= tail + allocNum;
        count <= count + CTI_COUNT_WIDTH'(allocNum) - CTI_COUNT_WIDTH'(commitFire);
      end
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        if (allocEn_i && alloc_i[k] && !flagRecoverEx_i) begin
          entryResolved[tag_o[k]] <= 1'b0;
        end
      end
      if (ctrlVerified_i) begin
        entryResolved[ctiQueueIndex_i] <= 1'b1;
      end
    end
  end

  // Entry payload and update registers
  always_ff @(posedge clk) begin
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      if (allocEn_i && alloc_i[k] && !flagRecoverEx_i) begin
        entryPc[tag_o[k]]    <= slotPc_i[k];
        entryClass[tag_o[k]] <= slotClass_i[k];
      end
    end
    if (ctrlVerified_i) begin
      entryDir[ctiQueueIndex_i]    <= branchOutcome_i;
      entryTarget[ctiQueueIndex_i] <= targetAddr_i;
    end
    if (commitFire) begin
      updatePc_o         <= entryPc[head];
      updateTargetAddr_o <= entryTarget[head];
      updateCtrlClass_o  <= entryClass[head];
      updateDir_o        <= entryDir[head];
    end
  end

endmodule

//--- design/fetchPkg.sv
/*
 * Fetch stage 2 package
 * Widths, queue sizing, control classes, opcodes and the
 * instruction-word union shared by the second fetch stage.
 */

package fetchPkg;

  // Bundle and word geometry
  localparam int FETCH_WIDTH    = 4;
  localparam int SLOT_IDX_WIDTH = 2;
  localparam int PC_WIDTH       = 32;
  localparam int INSTR_WIDTH    = 32;
  localparam int PC_STEP        = 4;

  // Control-transfer queue
  localparam int CTI_QUEUE_DEPTH = 16;
  localparam int CTI_TAG_WIDTH   = 4;
  localparam int CTI_COUNT_WIDTH = 5;

  // Packet is {instruction, pc, target, tag, prediction}
  localparam int PACKET_WIDTH = INSTR_WIDTH + 2 * PC_WIDTH + CTI_TAG_WIDTH + 1;

  // Opcodes recognized by pre-decode
  localparam logic [5:0] OP_J   = 6'h02;
  localparam logic [5:0] OP_JAL = 6'h03;
  localparam logic [5:0] OP_BEQ = 6'h04;
  localparam logic [5:0] OP_BNE = 6'h05;
  localparam logic [5:0] OP_JR  = 6'h08;

  typedef enum logic [1:0] {
    CLS_RETURN = 2'd0,
    CLS_CALL   = 2'd1,
    CLS_JUMP   = 2'd2,
    CLS_BRANCH = 2'd3
  } ctrlClassT;

  // Same word seen as a branch or as a jump
  typedef union packed {
    struct packed {
      logic [5:0]         opcode;
      logic [4:0]         rs;
      logic [4:0]         rt;
      logic signed [15:0] offset;
    } branchView;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;
    } jumpView;
  } instrWordT;

endpackage

//--- design/fetchStage2.sv
/*
 * Fetch stage 2
 * Splits a four-wide bundle, pre-decodes every slot, finds the first
 * taken control instruction, invalidates the slots after it and
 * requests recovery when the predictor missed it. Surviving control
 * instructions are tagged in the control-transfer queue.
 */

`timescale 1ns/1ns

module fetchStage2
  import fetchPkg::*;
(
  input  logic                               clk,
  input  logic                               rst_i,
  input  logic [PC_WIDTH-1:0]                pc_i,
  input  logic [FETCH_WIDTH*INSTR_WIDTH-1:0] instructionBundle_i,
  input  logic                               fs1Ready_i,
  input  logic [FETCH_WIDTH-1:0]             btbHit_i,
  input  logic [FETCH_WIDTH-1:0]             prediction_i,
  input  logic [PC_WIDTH-1:0]                addrRas_i,
  input  logic                               stall_i,
  input  logic [CTI_TAG_WIDTH-1:0]           ctiQueueIndex_i,
  input  logic [PC_WIDTH-1:0]                targetAddr_i,
  input  logic                               branchOutcome_i,
  input  logic                               ctrlVerified_i,
  input  logic                               flagRecoverEx_i,
  input  logic                               commitCti_i,
  output logic [FETCH_WIDTH-1:0]             instValid_o,
  output logic [PACKET_WIDTH-1:0]            inst0Packet_o,
  output logic [PACKET_WIDTH-1:0]            inst1Packet_o,
  output logic [PACKET_WIDTH-1:0]            inst2Packet_o,
  output logic [PACKET_WIDTH-1:0]            inst3Packet_o,
  output logic                               flagRecoverId_o,
  output logic [PC_WIDTH-1:0]                targetAddrId_o,
  output logic                               flagRtrId_o,
  output logic                               flagCallId_o,
  output logic [PC_WIDTH-1:0]                callPcId_o,
  output logic [PC_WIDTH-1:0]                updatePc_o,
  output logic [PC_WIDTH-1:0]                updateTargetAddr_o,
  output ctrlClassT                          updateCtrlClass_o,
  output logic                               updateDir_o,
  output logic                               updateEn_o,
  output logic                               fs2Ready_o,
  output logic                               ctiQueueFull_o
);

  logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0]   slotInstr;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]      slotPc;
  logic [FETCH_WIDTH-1:0]                    slotIsCtrl;
  ctrlClassT [FETCH_WIDTH-1:0]               slotClass;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]      slotTarget;
  logic [FETCH_WIDTH-1:0][CTI_TAG_WIDTH-1:0] slotTag;
  logic [FETCH_WIDTH-1:0]                    slotTaken;
  logic [FETCH_WIDTH-1:0][PACKET_WIDTH-1:0]  packet;

  logic [FETCH_WIDTH-1:0]    validVec;
  logic [FETCH_WIDTH-1:0]    allocVec;
  logic                      allocEn;
  logic                      firstTaken;
  logic [SLOT_IDX_WIDTH-1:0] selSlot;
  logic                      flagRecover;
  logic                      ctiQueueFull;

  // Slot 0 sits in the low word of the bundle
  assign slotInstr = instructionBundle_i;

  for (genvar k = 0; k < FETCH_WIDTH; k++) begin : gSlot
    assign slotPc[k] = pc_i + PC_WIDTH'(k * PC_STEP);

    preDecode i_preDecode (
      .pc_i          (slotPc[k]),
      .instruction_i (slotInstr[k]),
      .addrRas_i     (addrRas_i),
      .isCtrl_o      (slotIsCtrl[k]),
      .ctrlClass_o   (slotClass[k]),
      .target_o      (slotTarget[k])
    );

    // Unconditional transfers always redirect
    assign slotTaken[k] = slotIsCtrl[k] & ((slotClass[k] != CLS_BRANCH) | prediction_i[k]);

    assign packet[k] = {slotInstr[k], slotPc[k], slotTarget[k], slotTag[k], prediction_i[k]};
  end

  // Lowest taken slot wins
  always_comb begin
    firstTaken = 1'b0;
    selSlot    = '0;
    for (int k = FETCH_WIDTH - 1; k >= 0; k--) begin
      if (slotTaken[k]) begin
        firstTaken = 1'b1;
        selSlot    = SLOT_IDX_WIDTH'(k);
      end
    end
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      validVec[k] = !firstTaken || (SLOT_IDX_WIDTH'(k) <= selSlot);
    end
  end

  // Predictor miss on the redirecting slot
  assign flagRecover    = firstTaken & ~btbHit_i[selSlot];
  assign flagRtrId_o    = flagRecover & (slotClass[selSlot] == CLS_RETURN);
  assign flagCallId_o   = flagRecover & (slotClass[selSlot] == CLS_CALL);
  assign targetAddrId_o = slotTarget[selSlot];
  assign callPcId_o     = slotPc[selSlot];

  assign flagRecoverId_o = flagRecover & ~stall_i & ~ctiQueueFull;

  assign allocVec = validVec & slotIsCtrl;
  assign allocEn  = fs1Ready_i & ~stall_i & ~ctiQueueFull;

  ctrlQueue i_ctrlQueue (
    .clk                (clk),
    .rst_i              (rst_i),
    .alloc_i            (allocVec),
    .allocEn_i          (allocEn),
    .slotPc_i           (slotPc),
    .slotClass_i        (slotClass),
    .tag_o              (slotTag),
    .full_o             (ctiQueueFull),
    .ctiQueueIndex_i    (ctiQueueIndex_i),
    .targetAddr_i       (targetAddr_i),
    .branchOutcome_i    (branchOutcome_i),
    .ctrlVerified_i     (ctrlVerified_i),
    .flagRecoverEx_i    (flagRecoverEx_i),
    .commitCti_i        (commitCti_i),
    .updatePc_o         (updatePc_o),
    .updateTargetAddr_o (updateTargetAddr_o),
    .updateCtrlClass_o  (updateCtrlClass_o),
    .updateDir_o        (updateDir_o),
    .updateEn_o         (updateEn_o)
  );

  assign instValid_o    = validVec;
  assign inst0Packet_o  = packet[0];
  assign inst1Packet_o  = packet[1];
  assign inst2Packet_o  = packet[2];
  assign inst3Packet_o  = packet[3];
  assign ctiQueueFull_o = ctiQueueFull;
  assign fs2Ready_o     = fs1Ready_i & ~ctiQueueFull;

endmodule

//--- design/preDecode.sv
/*
 * Pre-decode for one fetch slot
 * Classifies the instruction as return, call, jump or conditional
 * branch and computes its target. Returns take the return-stack
 * address, branches are PC relative, jumps and calls are region
 * absolute.
 */

`timescale 1ns/1ns

module preDecode
  import fetchPkg::*;
(
  input  logic [PC_WIDTH-1:0] pc_i,
  input  instrWordT           instruction_i,
  input  logic [PC_WIDTH-1:0] addrRas_i,
  output logic                isCtrl_o,
  output ctrlClassT           ctrlClass_o,
  output logic [PC_WIDTH-1:0] target_o
);

  logic [PC_WIDTH-1:0] seqPc;
  logic [PC_WIDTH-1:0] branchTarget;
  logic [PC_WIDTH-1:0] jumpTarget;

  assign seqPc = pc_i + PC_WIDTH'(PC_STEP);

  // Word offset scaled to bytes and sign extended
  assign branchTarget = seqPc + {{(PC_WIDTH - 18){instruction_i.branchView.offset[15]}},
                                 instruction_i.branchView.offset, 2'b00};

  // Upper PC bits select the region
  assign jumpTarget = {pc_i[PC_WIDTH-1:PC_WIDTH-4], instruction_i.jumpView.target, 2'b00};

  always_comb begin
    isCtrl_o    = 1'b1;
    ctrlClass_o = CLS_JUMP;
    target_o    = seqPc;
    case (instruction_i.jumpView.opcode)
      OP_JR: begin
        ctrlClass_o = CLS_RETURN;
        target_o    = addrRas_i;
      end
      OP_JAL: begin
        ctrlClass_o = CLS_CALL;
        target_o    = jumpTarget;
      end
      OP_J: begin
        ctrlClass_o = CLS_JUMP;
        target_o    = jumpTarget;
      end
      OP_BEQ, OP_BNE: begin
        ctrlClass_o = CLS_BRANCH;
        target_o    = branchTarget;
      end
      default: begin
        // Sequential instruction falls through
        isCtrl_o = 1'b0;
      end
    endcase
  end

endmodule

//--- filelist.f
design/fetchPkg.sv
design/preDecode.sv
design/ctrlQueue.sv
design/fetchStage2.sv
verification/fetchStage2_assertions.sv
verification/fetchStage2Tb.sv

//--- verification/fetchStage2Tb.sv
/*
 * Fetch stage 2 testbench
 * Random bundles, predictor bits and execute/commit traffic are
 * compared every cycle against a model of pre-decode, slot filtering
 * and the control-transfer queue.
 */

`timescale 1ns/1ns

module fetchStage2Tb
  import fetchPkg::*;
();

  localparam int NUM_CYCLES   = 400;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 3;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;

  logic clk = 1'b0;
  logic rst_i = 1'b1;
  logic [PC_WIDTH-1:0] pc_i = '0;
  logic [FETCH_WIDTH*INSTR_WIDTH-1:0] instructionBundle_i = '0;
  logic fs1Ready_i = 1'b0;
  logic [FETCH_WIDTH-1:0] btbHit_i = '0;
  logic [FETCH_WIDTH-1:0] prediction_i = '0;
  logic [PC_WIDTH-1:0] addrRas_i = '0;
  logic stall_i = 1'b0;
  logic [CTI_TAG_WIDTH-1:0] ctiQueueIndex_i = '0;
  logic [PC_WIDTH-1:0] targetAddr_i = '0;
  logic branchOutcome_i = 1'b0;
  logic ctrlVerified_i = 1'b0;
  logic flagRecoverEx_i = 1'b0;
  logic commitCti_i = 1'b0;

  logic [FETCH_WIDTH-1:0] instValid_o;
  logic [FETCH_WIDTH-1:0][PACKET_WIDTH-1:0] packets;
  logic flagRecoverId_o, flagRtrId_o, flagCallId_o;
  logic [PC_WIDTH-1:0] targetAddrId_o, callPcId_o, updatePc_o, updateTargetAddr_o;
  ctrlClassT updateCtrlClass_o;
  logic updateDir_o, updateEn_o, fs2Ready_o, ctiQueueFull_o;

  // Queue model
  logic [PC_WIDTH-1:0] mPc [CTI_QUEUE_DEPTH];
  ctrlClassT mClass [CTI_QUEUE_DEPTH];
  logic [PC_WIDTH-1:0] mTarget [CTI_QUEUE_DEPTH];
  logic mDir [CTI_QUEUE_DEPTH];
  logic mResolved [CTI_QUEUE_DEPTH];
  int mHead, mTail, mCount;
  logic expUpdEn, expUpdDir, lastAccepted;
  logic [PC_WIDTH-1:0] expUpdPc, expUpdTarget;
  ctrlClassT expUpdClass;
  int seed, nUpdates, nSquash, nFull, nRecover;

  fetchStage2 i_dut (
    .clk(clk), .rst_i(rst_i), .pc_i(pc_i), .instructionBundle_i(instructionBundle_i),
    .fs1Ready_i(fs1Ready_i), .btbHit_i(btbHit_i), .prediction_i(prediction_i),
    .addrRas_i(addrRas_i), .stall_i(stall_i), .ctiQueueIndex_i(ctiQueueIndex_i),
    .targetAddr_i(targetAddr_i), .branchOutcome_i(branchOutcome_i),
    .ctrlVerified_i(ctrlVerified_i), .flagRecoverEx_i(flagRecoverEx_i),
    .commitCti_i(commitCti_i), .instValid_o(instValid_o),
    .inst0Packet_o(packets[0]), .inst1Packet_o(packets[1]),
    .inst2Packet_o(packets[2]), .inst3Packet_o(packets[3]),
    .flagRecoverId_o(flagRecoverId_o), .targetAddrId_o(targetAddrId_o),
    .flagRtrId_o(flagRtrId_o), .flagCallId_o(flagCallId_o), .callPcId_o(callPcId_o),
    .updatePc_o(updatePc_o), .updateTargetAddr_o(updateTargetAddr_o),
    .updateCtrlClass_o(updateCtrlClass_o), .updateDir_o(updateDir_o),
    .updateEn_o(updateEn_o), .fs2Ready_o(fs2Ready_o), .ctiQueueFull_o(ctiQueueFull_o)
  );

  bind fetchStage2 fetchStage2Assertions i_assertions (
    .clk(clk), .rst_i(rst_i), .updateEn_i(updateEn_o), .flagRecoverId_i(flagRecoverId_o),
    .instValid_i(instValid_o), .selSlot_i(selSlot), .full_i(ctiQueueFull),
    .fs2Ready_i(fs2Ready_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int unsigned randBelow(input int unsigned n);
    randBelow = $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] randomInstr();
    logic [31:0] body;
    logic [5:0] op;
    body = $random(seed);
    case (randBelow(8))
      0: op = OP_J;
      1: op = OP_JAL;
      2: op = OP_BEQ;
      3: op = OP_BNE;
      4: op = OP_JR;
      5: op = 6'h00;
      6: op = 6'h0f;
      default: op = 6'h23;
    endcase
    randomInstr = {op, body[25:0]};
  endfunction

  // Returns {isCtrl, class}
  function automatic logic [2:0] decodeSlot(input logic [31:0] instr);
    case (instr[31:26])
      OP_JR: decodeSlot = {1'b1, CLS_RETURN};
      OP_JAL: decodeSlot = {1'b1, CLS_CALL};
      OP_J: decodeSlot = {1'b1, CLS_JUMP};
      OP_BEQ, OP_BNE: decodeSlot = {1'b1, CLS_BRANCH};
      default: decodeSlot = 3'b000;
    endcase
  endfunction

  function automatic logic [31:0] computeTarget(input logic [31:0] pc, input logic [31:0] instr,
                                                input logic [31:0] ras);
    logic [31:0] offset;
    offset = {{14{instr[15]}}, instr[15:0], 2'b00};
    case (instr[31:26])
      OP_JR: computeTarget = ras;
      OP_J, OP_JAL: computeTarget = {pc[31:28], instr[25:0], 2'b00};
      default: computeTarget = pc + 32'd4 + offset;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
    if (actual !== expected) begin
      $display("error %s expected %0h actual %0h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic checkCycle();
    logic [2:0] dec [FETCH_WIDTH];
    logic [31:0] instr, pc;
    logic [FETCH_WIDTH-1:0] expValid;
    logic found, miss, full, expRecover;
    int sel, offset;
    #1;
    found = 1'b0;
    sel = 0;
    offset = 0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      dec[k] = decodeSlot(instructionBundle_i[k*32 +: 32]);
      if (!found && dec[k][2] && (dec[k][1:0] != CLS_BRANCH || prediction_i[k])) begin
        found = 1'b1;
        sel = k;
      end
    end
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      expValid[k] = !found || k <= sel;
      instr = instructionBundle_i[k*32 +: 32];
      pc = pc_i + 32'(4 * k);
      // Packet bits are {instr, pc, target, tag, prediction}
      checkValue($sformatf("slot%0d fields", k),
                 128'({instr, pc, 4'(mTail + offset), prediction_i[k]}),
                 128'({packets[k][100:37], packets[k][4:0]}));
      if (dec[k][2]) begin
        checkValue($sformatf("slot%0d target", k), 128'(computeTarget(pc, instr, addrRas_i)),
                   128'(packets[k][36:5]));
      end
      if (expValid[k] && dec[k][2]) offset++;
    end
    full = mCount > CTI_QUEUE_DEPTH - FETCH_WIDTH;
    miss = found && !btbHit_i[sel];
    expRecover = miss && !stall_i && !full;
    checkValue("valid", 128'(expValid), 128'(instValid_o));
    checkValue("queue full", 128'(full), 128'(ctiQueueFull_o));
    checkValue("fs2 ready", 128'(fs1Ready_i && !full), 128'(fs2Ready_o));
    checkValue("recover", 128'(expRecover), 128'(flagRecoverId_o));
    checkValue("return flag", 128'(miss && dec[sel][1:0] == CLS_RETURN), 128'(flagRtrId_o));
    checkValue("call flag", 128'(miss && dec[sel][1:0] == CLS_CALL), 128'(flagCallId_o));
    if (expRecover) begin
      checkValue("recover target", 128'(computeTarget(pc_i + 32'(4 * sel),
                 instructionBundle_i[sel*32 +: 32], addrRas_i)), 128'(targetAddrId_o));
      checkValue("recover pc", 128'(pc_i + 32'(4 * sel)), 128'(callPcId_o));
      nRecover++;
    end
    if (full) nFull++;
    checkValue("update enable", 128'(expUpdEn), 128'(updateEn_o));
    if (expUpdEn) begin
      checkValue("update pc", 128'(expUpdPc), 128'(updatePc_o));
      checkValue("update target", 128'(expUpdTarget), 128'(updateTargetAddr_o));
      checkValue("update class", 128'(expUpdClass), 128'(updateCtrlClass_o));
      checkValue("update dir", 128'(expUpdDir), 128'(updateDir_o));
      nUpdates++;
    end
    checkValue("assertions", 128'(0), 128'({i_dut.i_assertions.resetUpdateFail,
               i_dut.i_assertions.recoverValidFail, i_dut.i_assertions.readyFullFail}));
  endtask

  // Advances the queue model to the state after the next clock edge
  task automatic modelStep();
    logic fire, taken;
    logic [2:0] dec;
    int idx;
    idx = int'(ctiQueueIndex_i);
    fire = commitCti_i && mCount != 0 && mResolved[mHead];
    expUpdEn = fire;
    if (fire) begin
      expUpdPc = mPc[mHead];
      expUpdTarget = mTarget[mHead];
      expUpdClass = mClass[mHead];
      expUpdDir = mDir[mHead];
    end
    lastAccepted = fs1Ready_i && !stall_i && !(mCount > CTI_QUEUE_DEPTH - FETCH_WIDTH);
    if (ctrlVerified_i) begin
      mResolved[idx] = 1'b1;
      mDir[idx] = branchOutcome_i;
      mTarget[idx] = targetAddr_i;
    end
    if (flagRecoverEx_i) begin
      mCount = ((idx - mHead + CTI_QUEUE_DEPTH) % CTI_QUEUE_DEPTH) + 1;
      mTail = (idx + 1) % CTI_QUEUE_DEPTH;
      nSquash++;
    end else if (lastAccepted) begin
      taken = 1'b0;
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        dec = decodeSlot(instructionBundle_i[k*32 +: 32]);
        if (!taken && dec[2]) begin
          mPc[mTail] = pc_i + 32'(4 * k);
          mClass[mTail] = ctrlClassT'(dec[1:0]);
          mResolved[mTail] = 1'b0;
          mTail = (mTail + 1) % CTI_QUEUE_DEPTH;
          mCount++;
          taken = dec[1:0] != CLS_BRANCH || prediction_i[k];
        end
      end
    end
    if (fire) begin
      mCount--;
      mHead = (mHead + 1) % CTI_QUEUE_DEPTH;
    end
  endtask

  task automatic driveRandom();
    int span;
    // Upstream holds the bundle until the stage takes it
    if (lastAccepted) begin
      pc_i = 32'($random(seed)) & 32'hffff_fffc;
      for (int k = 0; k < FETCH_WIDTH; k++) instructionBundle_i[k*32 +: 32] = randomInstr();
      btbHit_i = 4'($random(seed));
      prediction_i = 4'($random(seed));
      addrRas_i = 32'($random(seed)) & 32'hffff_fffc;
    end
    fs1Ready_i = randBelow(8) != 0;
    stall_i = randBelow(8) == 0;
    ctrlVerified_i = 1'b0;
    flagRecoverEx_i = 1'b0;
    if (mCount > 0) begin
      // Mostly resolve the oldest entries so commits keep flowing
      span = mCount < 4 ? mCount : 4;
      ctiQueueIndex_i = 4'((mHead + int'(randBelow(span))) % CTI_QUEUE_DEPTH);
      ctrlVerified_i = randBelow(2) == 0;
      flagRecoverEx_i = randBelow(24) == 0;
    end
    branchOutcome_i = 1'(randBelow(2));
    targetAddr_i = 32'($random(seed));
    commitCti_i = randBelow(2) == 0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Some tests failed");
    $fatal(1);
  end

  initial begin
    seed = 48;
    mHead = 0;
    mTail = 0;
    mCount = 0;
    expUpdEn = 1'b0;
    lastAccepted = 1'b0;
    nUpdates = 0;
    nSquash = 0;
    nFull = 0;
    nRecover = 0;
    for (int i = 0; i < CTI_QUEUE_DEPTH; i++) mResolved[i] = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    // Four not-taken branches tag every slot from 0
    for (int k = 0; k < FETCH_WIDTH; k++) instructionBundle_i[k*32 +: 32] = {OP_BEQ, 10'd0, 16'(k)};
    pc_i = 32'h0000_1000;
    btbHit_i = '1;
    checkCycle();
    modelStep();
    @(negedge clk);
    fs1Ready_i = 1'b1;
    checkCycle();
    modelStep();
    repeat (NUM_CYCLES) begin
      @(negedge clk);
      driveRandom();
      checkCycle();
      modelStep();
    end
    if (nUpdates == 0 || nSquash == 0 || nFull == 0 || nRecover == 0) begin
      $display("random traffic never produced updates, squashes, a full queue and recovery");
      $display("Some tests failed");
      $fatal(1);
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

//--- verification/fetchStage2_assertions.sv
/*
 * Fetch stage 2 assertions
 * Bound into the top level to watch the update pulse after reset,
 * the recovery request against the valid vector and the ready/full pair.
 */

`timescale 1ns/1ns

module fetchStage2Assertions
  import fetchPkg::*;
(
  input logic                      clk,
  input logic                      rst_i,
  input logic                      updateEn_i,
  input logic                      flagRecoverId_i,
  input logic [FETCH_WIDTH-1:0]    instValid_i,
  input logic [SLOT_IDX_WIDTH-1:0] selSlot_i,
  input logic                      full_i,
  input logic                      fs2Ready_i
);

  // Sticky flags read by the testbench
  logic resetUpdateFail   = 1'b0;
  logic recoverValidFail  = 1'b0;
  logic readyFullFail     = 1'b0;

  assert property (@(posedge clk) rst_i |=> !updateEn_i)
    else begin
      resetUpdateFail = 1'b1;
      $error("update pulse in the cycle after reset");
    end

  assert property (@(posedge clk) disable iff (rst_i) flagRecoverId_i |-> instValid_i[selSlot_i])
    else begin
      recoverValidFail = 1'b1;
      $error("recovery requested for an invalid slot");
    end

  assert property (@(posedge clk) disable iff (rst_i) !(full_i && fs2Ready_i))
    else begin
      readyFullFail = 1'b1;
      $error("stage ready while the queue is full");
    end

endmodule
